// ==== hdl/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    parameter int XLEN   = 32;
    parameter int NREG   = 16;
    parameter int REG_AW = $clog2(NREG);
    parameter int IMM_W  = 16;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_OR   = 3'd4,
        OP_ADDI = 3'd5,
        OP_LD   = 3'd6,
        OP_ST   = 3'd7
    } opcode_e;

    // 32-bit instruction word as sent by the frontend
    typedef struct packed {
        opcode_e             op;
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [IMM_W-1:0]    imm;
        logic                spare;
    } inst_t;

    typedef struct packed {
        logic                valid;
        opcode_e             op;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
        logic [XLEN-1:0]     store_data;
    } disp_ex_t;

    typedef struct packed {
        logic                valid;
        opcode_e             op;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     result;
        logic [XLEN-1:0]     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                wr_en;
        logic [REG_AW-1:0]   wr_addr;
        logic [XLEN-1:0]     wr_data;
    } fwd_t;

    // for a store, data carries the store address
    typedef struct packed {
        logic                valid;
        opcode_e             op;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     data;
    } retire_t;

    // ops that produce a register result
    function automatic logic writes_reg(input opcode_e op);
        return (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
               (op == OP_OR) || (op == OP_ADDI) || (op == OP_LD);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  backend_pkg::inst_t    inst_i,
    input  logic                  stall_i,
    output logic                  head_valid_o,
    output backend_pkg::inst_t    head_o,
    output logic                  credit_o
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    backend_pkg::inst_t entries_q [BUF_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               pop;

    assign head_valid_o = (count_q != '0);
    assign head_o       = entries_q[rd_ptr_q];
    assign pop          = head_valid_o && !stall_i;
    // each freed entry hands one credit back
    assign credit_o     = pop;

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            entries_q[wr_ptr_q] <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (inst_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(inst_valid_i) - CNT_W'(pop);
        end
    end

    // frontend must hold a credit for every send
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_valid_i |-> (count_q != CNT_W'(BUF_DEPTH)))
        else $error("inst_buffer: write while full");

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q <= CNT_W'(BUF_DEPTH))
        else $error("inst_buffer: occupancy above depth");

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic [backend_pkg::REG_AW-1:0]   raddr_a_i,
    input  logic [backend_pkg::REG_AW-1:0]   raddr_b_i,
    input  backend_pkg::fwd_t                wr_i,
    output logic [backend_pkg::XLEN-1:0]     rdata_a_o,
    output logic [backend_pkg::XLEN-1:0]     rdata_b_o
);

    logic [backend_pkg::XLEN-1:0] regs_q [backend_pkg::NREG];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < backend_pkg::NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.wr_en && (wr_i.wr_addr != '0)) begin
            regs_q[wr_i.wr_addr] <= wr_i.wr_data;
        end
    end

    // r0 reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    // writeback drops r0 writes before they reach the port
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_i.wr_en |-> (wr_i.wr_addr != '0))
        else $error("regfile: write to register 0 reached the write port");

endmodule

`default_nettype wire

// ==== hdl/dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             head_valid_i,
    input  backend_pkg::inst_t               head_i,
    input  backend_pkg::fwd_t                ex_fwd_i,
    input  backend_pkg::fwd_t                mem_fwd_i,
    input  backend_pkg::fwd_t                wb_fwd_i,
    input  logic                             ex_is_load_i,
    input  logic [backend_pkg::REG_AW-1:0]   ex_rd_i,
    output logic                             stall_o,
    output backend_pkg::disp_ex_t            disp_o
);

    logic [backend_pkg::XLEN-1:0] rf_a;
    logic [backend_pkg::XLEN-1:0] rf_b;
    logic [backend_pkg::XLEN-1:0] val_rs1;
    logic [backend_pkg::XLEN-1:0] val_rs2;
    logic [backend_pkg::XLEN-1:0] imm_ext;
    logic                         uses_rs1;
    logic                         uses_rs2;
    logic                         imm_b;

    regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (head_i.rs1),
        .raddr_b_i (head_i.rs2),
        .wr_i      (wb_fwd_i),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    // youngest producer wins
    function automatic logic [backend_pkg::XLEN-1:0] pick_operand(
        input logic [backend_pkg::REG_AW-1:0] addr,
        input logic [backend_pkg::XLEN-1:0]   rf_val
    );
        logic [backend_pkg::XLEN-1:0] val;
        val = rf_val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd_i.wr_en && (ex_fwd_i.wr_addr == addr)) begin
            val = ex_fwd_i.wr_data;
        end else if (mem_fwd_i.wr_en && (mem_fwd_i.wr_addr == addr)) begin
            val = mem_fwd_i.wr_data;
        end else if (wb_fwd_i.wr_en && (wb_fwd_i.wr_addr == addr)) begin
            val = wb_fwd_i.wr_data;
        end
        return val;
    endfunction

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm_b    = 1'b0;
        unique case (head_i.op)
            backend_pkg::OP_ADD, backend_pkg::OP_SUB,
            backend_pkg::OP_AND, backend_pkg::OP_OR: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            backend_pkg::OP_ADDI, backend_pkg::OP_LD: begin
                uses_rs1 = 1'b1;
                imm_b    = 1'b1;
            end
            // address from rs1, data from rs2
            backend_pkg::OP_ST: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm_b    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        val_rs1 = pick_operand(head_i.rs1, rf_a);
        val_rs2 = pick_operand(head_i.rs2, rf_b);
    end

    assign imm_ext = {{(backend_pkg::XLEN - backend_pkg::IMM_W){head_i.imm[backend_pkg::IMM_W-1]}},
                      head_i.imm};

    // load result only exists after the memory stage
    assign stall_o = head_valid_i && ex_is_load_i && (ex_rd_i != '0) &&
                     ((uses_rs1 && (head_i.rs1 == ex_rd_i)) ||
                      (uses_rs2 && (head_i.rs2 == ex_rd_i)));

    always_comb begin
        disp_o.valid      = head_valid_i && !stall_o;
        disp_o.op         = head_i.op;
        disp_o.rd         = head_i.rd;
        disp_o.a          = val_rs1;
        disp_o.b          = imm_b ? imm_ext : val_rs2;
        disp_o.store_data = val_rs2;
    end

    // the bubble lets the load move on, so a stall never repeats
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o)
        else $error("dispatch: load-use stall held for more than one cycle");

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  backend_pkg::disp_ex_t            disp_i,
    output backend_pkg::ex_mem_t             ex_o,
    output backend_pkg::fwd_t                fwd_o,
    output logic                             is_load_o,
    output logic [backend_pkg::REG_AW-1:0]   rd_o
);

    backend_pkg::disp_ex_t        d_q;
    logic [backend_pkg::XLEN-1:0] result;

    always_ff @(posedge clk) begin
        d_q <= disp_i;
        if (!rst_n_i) begin
            d_q.valid <= 1'b0;
        end
    end

    always_comb begin
        unique case (d_q.op)
            // loads and stores use the adder for the address
            backend_pkg::OP_ADD, backend_pkg::OP_ADDI,
            backend_pkg::OP_LD, backend_pkg::OP_ST: result = d_q.a + d_q.b;
            backend_pkg::OP_SUB:                    result = d_q.a - d_q.b;
            backend_pkg::OP_AND:                    result = d_q.a & d_q.b;
            backend_pkg::OP_OR:                     result = d_q.a | d_q.b;
            default:                                result = '0;
        endcase
    end

    always_comb begin
        ex_o.valid      = d_q.valid;
        ex_o.op         = d_q.op;
        ex_o.rd         = d_q.rd;
        ex_o.result     = result;
        ex_o.store_data = d_q.store_data;
    end

    // load data not ready yet, so no forward
    assign fwd_o.wr_en   = d_q.valid && backend_pkg::writes_reg(d_q.op) &&
                           (d_q.op != backend_pkg::OP_LD) && (d_q.rd != '0);
    assign fwd_o.wr_addr = d_q.rd;
    assign fwd_o.wr_data = result;

    assign is_load_o = d_q.valid && (d_q.op == backend_pkg::OP_LD);
    assign rd_o      = d_q.rd;

endmodule

`default_nettype wire

// ==== hdl/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::ex_mem_t   ex_i,
    output backend_pkg::ex_mem_t   mem_o,
    output backend_pkg::fwd_t      fwd_o
);

    localparam int AW = $clog2(DMEM_WORDS);

    backend_pkg::ex_mem_t         m_q;
    logic [backend_pkg::XLEN-1:0] dmem_q [DMEM_WORDS];
    logic [AW-1:0]                word_idx;
    logic                         is_ld;
    logic                         is_st;

    always_ff @(posedge clk) begin
        m_q <= ex_i;
        if (!rst_n_i) begin
            m_q.valid <= 1'b0;
        end
    end

    // drop the byte offset, wrap to memory size
    assign word_idx = m_q.result[AW+1:2];
    assign is_ld    = m_q.valid && (m_q.op == backend_pkg::OP_LD);
    assign is_st    = m_q.valid && (m_q.op == backend_pkg::OP_ST);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem_q[i] <= '0;
            end
        end else if (is_st) begin
            dmem_q[word_idx] <= m_q.store_data;
        end
    end

    always_comb begin
        mem_o.valid      = m_q.valid;
        mem_o.op         = m_q.op;
        mem_o.rd         = m_q.rd;
        mem_o.result     = is_ld ? dmem_q[word_idx] : m_q.result;
        mem_o.store_data = m_q.store_data;
    end

    assign fwd_o.wr_en   = m_q.valid && backend_pkg::writes_reg(m_q.op) && (m_q.rd != '0);
    assign fwd_o.wr_addr = m_q.rd;
    assign fwd_o.wr_data = mem_o.result;

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        (is_ld || is_st) |-> (m_q.result[1:0] == 2'b00))
        else $error("mem_access: unaligned address %h", m_q.result);

endmodule

`default_nettype wire

// ==== hdl/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend #(
    parameter int BUF_DEPTH  = 4,
    parameter int DMEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  backend_pkg::inst_t    inst_i,
    output logic                  credit_o,
    output backend_pkg::retire_t  retire_o
);

    // buffer
    logic                 head_valid;
    backend_pkg::inst_t   head;
    logic                 stall;

    // dispatch
    backend_pkg::disp_ex_t disp;

    // execute
    backend_pkg::ex_mem_t             ex_out;
    backend_pkg::fwd_t                ex_fwd;
    logic                             ex_is_load;
    logic [backend_pkg::REG_AW-1:0]   ex_rd;

    // memory
    backend_pkg::ex_mem_t mem_out;
    backend_pkg::fwd_t    mem_fwd;

    // writeback and retire
    backend_pkg::retire_t wb_q;
    backend_pkg::retire_t retire_q;
    backend_pkg::fwd_t    wb_fwd;

    inst_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_inst_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_i      (stall),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (credit_o)
    );

    dispatch u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .wb_fwd_i     (wb_fwd),
        .ex_is_load_i (ex_is_load),
        .ex_rd_i      (ex_rd),
        .stall_o      (stall),
        .disp_o       (disp)
    );

    execute u_execute (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .disp_i    (disp),
        .ex_o      (ex_out),
        .fwd_o     (ex_fwd),
        .is_load_o (ex_is_load),
        .rd_o      (ex_rd)
    );

    mem_access #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_access (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_out),
        .mem_o   (mem_out),
        .fwd_o   (mem_fwd)
    );

    always_ff @(posedge clk) begin
        wb_q.op   <= mem_out.op;
        wb_q.rd   <= mem_out.rd;
        wb_q.data <= mem_out.result;
        retire_q  <= wb_q;
        if (!rst_n_i) begin
            wb_q.valid     <= 1'b0;
            retire_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= mem_out.valid;
        end
    end

    // register file write port
    assign wb_fwd.wr_en   = wb_q.valid && backend_pkg::writes_reg(wb_q.op) && (wb_q.rd != '0);
    assign wb_fwd.wr_addr = wb_q.rd;
    assign wb_fwd.wr_data = wb_q.data;

    assign retire_o = retire_q;

endmodule

`default_nettype wire

// ==== bench/backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

    localparam int BUF_DEPTH  = 4;
    localparam int DMEM_WORDS = 64;
    localparam int NTESTS     = 5;

    logic                 clk;
    logic                 rst_n_i;
    logic                 inst_valid_i;
    backend_pkg::inst_t   inst_i;
    logic                 credit_o;
    backend_pkg::retire_t retire_o;

    // all rows end to end, first[] marks where each test starts
    backend_pkg::inst_t   prog [$];
    int                   first [NTESTS];
    int                   len [NTESTS];
    bit                   gap [NTESTS];
    string                names [NTESTS];
    backend_pkg::retire_t exp_q [$];
    logic [31:0]          mregs [16];
    logic [31:0]          mmem [DMEM_WORDS];
    int                   seed = 71;
    int                   cycles;
    int                   limit;
    int                   errors;
    int                   passed;
    int                   failed;

    backend #(
        .BUF_DEPTH  (BUF_DEPTH),
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .credit_o     (credit_o),
        .retire_o     (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic put_inst(input backend_pkg::opcode_e op, input int rd, input int rs1,
                            input int rs2, input logic [15:0] imm);
        backend_pkg::inst_t w;
        w = {op, 4'(rd), 4'(rs1), 4'(rs2), imm, 1'b0};
        prog.push_back(w);
    endtask

    task automatic open_test(input int t, input string name, input bit g);
        first[t] = prog.size();
        names[t] = name;
        gap[t]   = g;
    endtask

    task automatic build_table();
        open_test(0, "alu", 1'b0);
        put_inst(backend_pkg::OP_ADDI, 1, 0, 0, 16'd5);
        put_inst(backend_pkg::OP_ADDI, 2, 0, 0, 16'hfffd);
        put_inst(backend_pkg::OP_ADD, 3, 1, 2, 16'd0);
        put_inst(backend_pkg::OP_SUB, 4, 3, 1, 16'd0);
        put_inst(backend_pkg::OP_AND, 5, 4, 2, 16'd0);
        put_inst(backend_pkg::OP_OR, 6, 5, 3, 16'd0);
        open_test(1, "load_use", 1'b0);
        put_inst(backend_pkg::OP_ADDI, 1, 0, 0, 16'h77);
        put_inst(backend_pkg::OP_ST, 0, 0, 1, 16'd8);
        put_inst(backend_pkg::OP_LD, 2, 0, 0, 16'd8);
        put_inst(backend_pkg::OP_ADD, 3, 2, 2, 16'd0);
        put_inst(backend_pkg::OP_LD, 5, 0, 0, 16'd8);
        put_inst(backend_pkg::OP_OR, 6, 1, 5, 16'd0);
        open_test(2, "store_load", 1'b1);
        put_inst(backend_pkg::OP_ADDI, 1, 0, 0, 16'h123);
        put_inst(backend_pkg::OP_ADDI, 2, 0, 0, 16'd16);
        put_inst(backend_pkg::OP_ST, 0, 2, 1, 16'd4);
        put_inst(backend_pkg::OP_LD, 3, 2, 0, 16'd4);
        put_inst(backend_pkg::OP_LD, 4, 2, 0, 16'd8);
        // load-use pairs slow the pops until the buffer fills and credits run out
        open_test(3, "credits", 1'b0);
        put_inst(backend_pkg::OP_ADDI, 1, 6, 0, 16'h40);
        put_inst(backend_pkg::OP_ST, 0, 0, 1, 16'd0);
        for (int i = 0; i < 5; i++) begin
            put_inst(backend_pkg::OP_LD, 2, 0, 0, 16'd0);
            put_inst(backend_pkg::OP_ADDI, i + 3, 2, 0, 16'(i + 1));
        end
        open_test(4, "reg0", 1'b1);
        put_inst(backend_pkg::OP_ADDI, 0, 0, 0, 16'd9);
        put_inst(backend_pkg::OP_ADD, 1, 0, 0, 16'd0);
        put_inst(backend_pkg::OP_ADDI, 2, 0, 0, 16'd4);
        limit = 0;
        for (int t = 0; t < NTESTS; t++) begin
            len[t] = ((t == NTESTS - 1) ? prog.size() : first[t + 1]) - first[t];
            limit += 40 * len[t] + 20;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            $display("timeout: pipeline stopped retiring after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    endtask

    task automatic check_quiet(input string when);
        assert (!retire_o.valid && !credit_o)
            else begin
                $display("retire or credit active %s", when);
                errors++;
            end
    endtask

    task automatic reset_dut();
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (2) begin
            tick();
            check_quiet("during reset");
        end
        rst_n_i = 1'b1;
        tick();
        check_quiet("after reset with nothing sent");
    endtask

    // reference model over the test's program in issue order
    task automatic build_expected(input int t);
        backend_pkg::inst_t   w;
        backend_pkg::retire_t e;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          imm;
        int                   idx;
        for (int i = 0; i < 16; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mmem[i] = '0;
        end
        exp_q.delete();
        for (int i = 0; i < len[t]; i++) begin
            w       = prog[first[t] + i];
            a       = mregs[w.rs1];
            b       = mregs[w.rs2];
            imm     = {{16{w.imm[15]}}, w.imm};
            idx     = ((a + imm) >> 2) % DMEM_WORDS;
            e.valid = 1'b1;
            e.op    = w.op;
            e.rd    = w.rd;
            case (w.op)
                backend_pkg::OP_ADD:                     e.data = a + b;
                backend_pkg::OP_SUB:                     e.data = a - b;
                backend_pkg::OP_AND:                     e.data = a & b;
                backend_pkg::OP_OR:                      e.data = a | b;
                backend_pkg::OP_ADDI, backend_pkg::OP_ST: e.data = a + imm;
                backend_pkg::OP_LD:                      e.data = mmem[idx];
                default:                                 e.data = '0;
            endcase
            if (w.op == backend_pkg::OP_ST) begin
                mmem[idx] = b;
            end else if (w.op != backend_pkg::OP_NOP && w.rd != 0) begin
                mregs[w.rd] = e.data;
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic check_retire(input int t);
        backend_pkg::retire_t e;
        e = exp_q.pop_front();
        assert (retire_o.op == e.op)
            else begin
                $display("mismatch test %0d op: got %h expected %h", t, retire_o.op, e.op);
                errors++;
            end
        assert (retire_o.rd == e.rd)
            else begin
                $display("mismatch test %0d rd: got %h expected %h", t, retire_o.rd, e.rd);
                errors++;
            end
        assert (retire_o.data == e.data)
            else begin
                $display("mismatch test %0d data: got %h expected %h", t, retire_o.data, e.data);
                errors++;
            end
    endtask

    task automatic run_test(input int t);
        int sent;
        int retired;
        int credits;
        int idle;
        errors  = 0;
        sent    = 0;
        retired = 0;
        credits = BUF_DEPTH;
        idle    = 0;
        reset_dut();
        build_expected(t);
        while (retired < len[t]) begin
            if (idle > 0) begin
                idle--;
                inst_valid_i = 1'b0;
            end else if (sent < len[t] && credits > 0) begin
                inst_valid_i = 1'b1;
                inst_i       = prog[first[t] + sent];
                sent++;
                credits--;
                if (gap[t]) begin
                    idle = $unsigned($random(seed)) % 4;
                end
            end else begin
                inst_valid_i = 1'b0;
            end
            // a returned credit is usable from the next cycle on
            if (credit_o) begin
                credits++;
            end
            assert (credits <= BUF_DEPTH)
                else begin
                    $display("test %0d: more credits returned than instructions sent", t);
                    errors++;
                end
            tick();
            if (retire_o.valid) begin
                check_retire(t);
                retired++;
            end
        end
        inst_valid_i = 1'b0;
        repeat (6) begin
            if (credit_o) begin
                credits++;
            end
            tick();
            assert (!retire_o.valid)
                else begin
                    $display("test %0d: retire seen after the last instruction", t);
                    errors++;
                end
        end
        assert (credits == BUF_DEPTH)
            else begin
                $display("mismatch test %0d credits: got %h expected %h", t, credits, BUF_DEPTH);
                errors++;
            end
        $display("test %0d %s: %0d retired, %0d errors", t, names[t], retired, errors);
    endtask

    initial begin
        cycles = 0;
        passed = 0;
        failed = 0;
        build_table();
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
            if (errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/backend_pkg.sv
hdl/inst_buffer.sv
hdl/regfile.sv
hdl/dispatch.sv
hdl/execute.sv
hdl/mem_access.sv
hdl/backend.sv
bench/backend_tb.sv
